//--- Bender.yml
package:
  name: multProcessor

sources:
  - files:
      - design/multPkg.sv
      - design/ctrlPkg.sv
      - design/buttonSync.sv
      - design/controlUnit.sv
      - design/multiplierDatapath.sv
      - design/hexDriver.sv
      - design/processor.sv

  - target: test
    files:
      - tests/processor_assert.sv
      - tests/testbench.sv

//--- design/buttonSync.sv
module buttonSync import multPkg::*; (
    input  logic    Clk,
    input  logic    reset,
    input  operandT sw,        // raw switches
    input  logic    loadClear, // raw load/clear level
    input  logic    run,       // raw run level
    output operandT swSync,
    output logic    loadSync,
    output logic    runLevel,
    output logic    runStart   // one cycle on run rising edge
);

    operandT swMeta;   // first stage, may go metastable
    logic    loadMeta;
    logic    runMeta;
    logic    runPrev;  // third flop, delayed runLevel for edge detect

    // switches are payload, no reset needed
    always_ff @(posedge Clk) begin
        swMeta <= sw;
        swSync <= swMeta;
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            loadMeta <= 1'b0;
            loadSync <= 1'b0;
            runMeta  <= 1'b0;
            runLevel <= 1'b0;
            runPrev  <= 1'b0;
        end else begin
            loadMeta <= loadClear;
            loadSync <= loadMeta;
            runMeta  <= run;
            runLevel <= runMeta;
            runPrev  <= runLevel;
        end
    end

    assign runStart = runLevel & ~runPrev; // rising edge only
endmodule

//--- design/controlUnit.sv
module controlUnit import multPkg::*; import ctrlPkg::*; (
    input  logic     Clk,
    input  logic     reset,
    input  logic     loadSync,  // load/clear level, synchronized
    input  logic     runLevel,  // run level, synchronized
    input  logic     runStart,  // run rising edge pulse
    input  logic     bLsb,      // current multiplier bit
    output ctrlCmdT  cmd
);

    localparam int cntWidth = $clog2(stepCount);

    // index of the last add/shift pair
    localparam logic [cntWidth-1:0] lastStep = cntWidth'(stepCount - 1);

    ctrlStateT             state;
    ctrlStateT             stateNext;
    logic [cntWidth-1:0]   stepCnt;   // which add/shift pair we are on
    logic                  lastPair;

    assign lastPair = (stepCnt == lastStep);

    // state and step counter
    always_ff @(posedge Clk) begin
        if (reset) begin
            state   <= idle;
            stepCnt <= '0;
        end else begin
            state <= stateNext;
            if (state == clearStep)
                stepCnt <= '0;               // fresh count each run
            else if (state == shiftStep && !lastPair)
                stepCnt <= stepCnt + 1'b1;   // advance after each shift
        end
    end

    // next state
    always_comb begin
        stateNext = state;
        unique case (state)
            idle: begin
                if (runStart)
                    stateNext = clearStep;
            end
            clearStep: stateNext = addStep;
            addStep:   stateNext = shiftStep;  // every add is followed by a shift
            shiftStep: begin
                if (lastPair)
                    stateNext = holdStep;      // eighth shift done
                else
                    stateNext = addStep;
            end
            holdStep: begin
                // one multiply per press
                if (!runLevel)
                    stateNext = idle;
            end
            default: stateNext = idle;
        endcase
    end

    // command decode, Moore except for bLsb and loadSync
    always_comb begin
        cmd = cmdNone;
        unique case (state)
            idle: begin
                cmd.loadB = loadSync;          // load/clear only honoured here
            end
            clearStep: begin
                cmd.clearAx = 1'b1;
            end
            addStep: begin
                // sign bit of B has negative weight, so the last step subtracts
                if (bLsb) begin
                    if (lastPair)
                        cmd.subM = 1'b1;
                    else
                        cmd.addM = 1'b1;
                end
            end
            shiftStep: begin
                cmd.shiftAll = 1'b1;
            end
            holdStep: begin
                cmd = cmdNone;                 // result held
            end
            default: cmd = cmdNone;
        endcase
    end

endmodule

//--- design/ctrlPkg.sv
package ctrlPkg;

    // controller states
    //   idle      : waits for run, passes load through as loadB
    //   clearStep : one cycle clearing A and X before the first step
    //   addStep   : conditional add (or subtract on the last step)
    //   shiftStep : arithmetic right shift of X:A:B
    //   holdStep  : result stable until run is released
    typedef enum logic [2:0] {
        idle      = 3'd0,
        clearStep = 3'd1,
        addStep   = 3'd2,
        shiftStep = 3'd3,
        holdStep  = 3'd4
    } ctrlStateT;

    // datapath command, at most one field high in a cycle
    typedef struct packed {
        logic loadB;    // B <= switches, A and X cleared
        logic clearAx;  // A and X cleared, B kept
        logic addM;     // X:A <= X:A + multiplicand
        logic subM;     // X:A <= X:A - multiplicand, sign bit step
        logic shiftAll; // X:A:B >>> 1, X keeps its value
    } ctrlCmdT;

    // all fields low
    localparam ctrlCmdT cmdNone = '{
        loadB:    1'b0,
        clearAx:  1'b0,
        addM:     1'b0,
        subM:     1'b0,
        shiftAll: 1'b0
    };

endpackage

//--- design/hexDriver.sv
module hexDriver import multPkg::*; (
    input  nibbleT nibble,
    output segT    seg      // active low, gfedcba
);

    always_comb begin
        unique case (nibble)
            4'h0: seg = 7'b1000000;
            4'h1: seg = 7'b1111001;
            4'h2: seg = 7'b0100100;
            4'h3: seg = 7'b0110000;
            4'h4: seg = 7'b0011001;
            4'h5: seg = 7'b0010010;
            4'h6: seg = 7'b0000010;
            4'h7: seg = 7'b1111000;
            4'h8: seg = 7'b0000000;
            4'h9: seg = 7'b0010000;
            4'hA: seg = 7'b0001000;
            4'hB: seg = 7'b0000011; // lower case b
            4'hC: seg = 7'b1000110;
            4'hD: seg = 7'b0100001; // lower case d
            4'hE: seg = 7'b0000110;
            4'hF: seg = 7'b0001110;
            default: seg = '1;      // blank
        endcase
    end

endmodule

//--- design/multPkg.sv
package multPkg;

    // operand width, also the width of A, B and the switches
    localparam int operandWidth = 8;

    // add/shift pairs per multiply, one per multiplier bit
    localparam int stepCount = operandWidth;

    // sum carries one extra bit so X gets the true sign
    localparam int sumWidth = operandWidth + 1;

    // seven-segment display widths
    localparam int segWidth    = 7;
    localparam int nibbleWidth = 4;

    // switch value, A and B contents
    typedef logic [operandWidth-1:0] operandT;

    // X:A sum, sign extended
    typedef logic [sumWidth-1:0] sumT;

    // active-low segment pattern, bit 0 is segment a
    typedef logic [segWidth-1:0] segT;

    // one hex digit on a display
    typedef logic [nibbleWidth-1:0] nibbleT;

endpackage

//--- design/multiplierDatapath.sv
module multiplierDatapath import multPkg::*; import ctrlPkg::*; (
    input  logic    Clk,
    input  logic    reset,
    input  ctrlCmdT cmd,
    input  operandT multiplicand, // synchronized switches
    output operandT aReg,         // high byte of product
    output operandT bReg,         // multiplier, low byte of product
    output logic    xReg,         // product sign
    output logic    bLsb
);

    sumT axVal;    // X:A as one 9-bit signed value
    sumT mExt;     // multiplicand sign extended to 9 bits
    sumT sum;

    assign axVal = {xReg, aReg};
    assign mExt  = {multiplicand[operandWidth-1], multiplicand};

    // single adder, subtract on the sign bit step
    always_comb begin
        if (cmd.subM)
            sum = axVal - mExt;
        else
            sum = axVal + mExt;
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            xReg <= 1'b0;
            aReg <= '0;
            bReg <= '0;
        end else begin
            if (cmd.loadB) begin
                bReg <= multiplicand;     // switches hold the multiplier here
                aReg <= '0;
                xReg <= 1'b0;
            end else if (cmd.clearAx) begin
                aReg <= '0;
                xReg <= 1'b0;             // B kept, allows rerun
            end else if (cmd.addM || cmd.subM) begin
                {xReg, aReg} <= sum;      // carry out of 9 bits dropped
            end else if (cmd.shiftAll) begin
                // arithmetic shift, X copies into A's top bit and stays
                aReg <= {xReg, aReg[operandWidth-1:1]};
                bReg <= {aReg[0], bReg[operandWidth-1:1]};
            end
        end
    end

    assign bLsb = bReg[0]; // bit the controller tests each step
endmodule

//--- design/processor.sv
module processor import multPkg::*; import ctrlPkg::*; (
    input  logic    Clk,
    input  logic    reset,
    input  operandT sw,
    input  logic    loadClear,
    input  logic    run,
    output segT     hex0,     // B low nibble
    output segT     hex1,     // B high nibble
    output segT     hex2,     // A low nibble
    output segT     hex3,     // A high nibble
    output operandT aVal,
    output operandT bVal,
    output logic    xVal
);

    operandT swSync;
    logic    loadSync;
    logic    runLevel;
    logic    runStart;
    logic    bLsb;
    ctrlCmdT cmd;

    buttonSync syncInst (
        .Clk       (Clk),
        .reset     (reset),
        .sw        (sw),
        .loadClear (loadClear),
        .run       (run),
        .swSync    (swSync),
        .loadSync  (loadSync),
        .runLevel  (runLevel),
        .runStart  (runStart)
    );

    controlUnit ctrlInst (
        .Clk      (Clk),
        .reset    (reset),
        .loadSync (loadSync),
        .runLevel (runLevel),
        .runStart (runStart),
        .bLsb     (bLsb),
        .cmd      (cmd)
    );

    multiplierDatapath dpInst (
        .Clk          (Clk),
        .reset        (reset),
        .cmd          (cmd),
        .multiplicand (swSync),
        .aReg         (aVal),
        .bReg         (bVal),
        .xReg         (xVal),
        .bLsb         (bLsb)
    );

    // displays, B on the right pair, A on the left pair
    hexDriver hex0Inst (.nibble(bVal[3:0]), .seg(hex0));
    hexDriver hex1Inst (.nibble(bVal[7:4]), .seg(hex1));
    hexDriver hex2Inst (.nibble(aVal[3:0]), .seg(hex2));
    hexDriver hex3Inst (.nibble(aVal[7:4]), .seg(hex3));

endmodule

//--- flist.f
design/multPkg.sv
design/ctrlPkg.sv
design/buttonSync.sv
design/controlUnit.sv
design/multiplierDatapath.sv
design/hexDriver.sv
design/processor.sv
tests/processor_assert.sv
tests/testbench.sv

//--- tests/multTrace.txt
# mode multiplier multiplicand expA expB expX, all hex
# rerun keeps B, its multiplier column is the B expected from the previous product
load  07 C5 FE 63 1
load  F9 3B FE 63 1
load  07 3B 01 9D 0
rerun 9D 03 FE D7 1
load  F9 C5 01 9D 0
load  74 74 34 90 0
load  8C 8C 34 90 0
load  8C 74 CB 70 1
rerun 70 FF FF 90 1
load  00 80 00 00 0
load  80 80 40 00 0

//--- tests/processor_assert.sv
module processor_assert import ctrlPkg::*; (
    input logic      Clk,
    input logic      reset,
    input ctrlStateT state,
    input ctrlCmdT   cmd,
    input logic      runStart
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [3:0]  addVisits;      // addStep cycles since the last clearStep
    int unsigned failCount = 0;  // read by the testbench at the end

    always_ff @(posedge Clk) begin
        if (reset)
            addVisits <= '0;
        else if (state == clearStep)
            addVisits <= '0;             // new multiply
        else if (state == addStep)
            addVisits <= addVisits + 1'b1;
    end

    // datapath takes one operation per cycle
    cmdOneHot: assert property (@(posedge Clk) disable iff (reset) $onehot0(cmd))
        else begin
            $error("more than one command field high: %b", cmd);
            failCount++;
        end

    // idle only ever passes load through
    idleQuiet: assert property (@(posedge Clk) disable iff (reset)
        (state == idle && !cmd.loadB) |-> (cmd == '0))
        else begin
            $error("command issued in idle without load: %b", cmd);
            failCount++;
        end

    // subtract belongs to the eighth add step only
    subLast: assert property (@(posedge Clk) disable iff (reset)
        cmd.subM |-> (addVisits == 4'd7))
        else begin
            $error("subtract issued after %0d add steps", addVisits);
            failCount++;
        end

    runToClear: assert property (@(posedge Clk) disable iff (reset)
        (state == idle && runStart) |=> (state == clearStep))
        else begin
            $error("run start in idle not followed by clear step");
            failCount++;
        end

endmodule

bind controlUnit processor_assert cmdChecks (
    .Clk      (Clk),
    .reset    (reset),
    .state    (state),
    .cmd      (cmd),
    .runStart (runStart)
);

//--- tests/testbench.sv
module testbench import multPkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int randomCount = 20;

    // one trace row or one random pair
    typedef struct packed {
        logic    rerun;  // keep B from the previous product
        operandT mpl;    // multiplier, or expected B before a rerun
        operandT mcd;    // multiplicand
        operandT expA;
        operandT expB;
        logic    expX;
    } vecT;

    logic    Clk;
    logic    reset;
    operandT sw;
    logic    loadClear;
    logic    run;
    segT     hex0;
    segT     hex1;
    segT     hex2;
    segT     hex3;
    operandT aVal;
    operandT bVal;
    logic    xVal;

    vecT         vecs[$];
    int unsigned lcgState    = 81640;
    int          errorCount  = 0;
    int          failedTests = 0;
    int          testIdx     = 0;
    int          cycleCount  = 0;
    int          cycleLimit  = 2 * (randomCount * 30 + 10); // redone once trace is read

    processor dut (
        .Clk       (Clk),
        .reset     (reset),
        .sw        (sw),
        .loadClear (loadClear),
        .run       (run),
        .hex0      (hex0),
        .hex1      (hex1),
        .hex2      (hex2),
        .hex3      (hex3),
        .aVal      (aVal),
        .bVal      (bVal),
        .xVal      (xVal)
    );

    initial begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;  // 100 ns period
    end

    // watchdog
    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: no end of tests after %0d cycles", cycleCount);
            $display("Simulation failed");
            $finish;
        end
    end

    // expected display pattern, active low gfedcba
    function automatic segT segFor(nibbleT n);
        case (n)
            4'h0: return 7'h40;
            4'h1: return 7'h79;
            4'h2: return 7'h24;
            4'h3: return 7'h30;
            4'h4: return 7'h19;
            4'h5: return 7'h12;
            4'h6: return 7'h02;
            4'h7: return 7'h78;
            4'h8: return 7'h00;
            4'h9: return 7'h10;
            4'hA: return 7'h08;
            4'hB: return 7'h03;
            4'hC: return 7'h46;
            4'hD: return 7'h21;
            4'hE: return 7'h06;
            default: return 7'h0E;  // F
        endcase
    endfunction

    function automatic operandT nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[23:16];  // middle bits, low ones cycle fast
    endfunction

    // inputs change 10 ns after the edge
    task automatic waitCycles(int n);
        repeat (n) @(posedge Clk);
        #10;
    endtask

    task automatic checkByte(string what, logic [7:0] got, logic [7:0] exp);
        assert (got === exp) else begin
            errorCount++;
            $display("[ERROR] %0d ns: test %0d %s is %h, expected %h",
                     $time, testIdx, what, got, exp);
        end
    endtask

    task automatic checkAll(string what, operandT expA, operandT expB, logic expX);
        checkByte({what, " A"}, aVal, expA);
        checkByte({what, " B"}, bVal, expB);
        checkByte({what, " X"}, {7'b0, xVal}, {7'b0, expX});
        checkByte({what, " hex0"}, {1'b0, hex0}, {1'b0, segFor(expB[3:0])});
        checkByte({what, " hex1"}, {1'b0, hex1}, {1'b0, segFor(expB[7:4])});
        checkByte({what, " hex2"}, {1'b0, hex2}, {1'b0, segFor(expA[3:0])});
        checkByte({what, " hex3"}, {1'b0, hex3}, {1'b0, segFor(expA[7:4])});
    endtask

    task automatic readTrace();
        int         fd;
        int         n;
        string      line;
        string      mode;
        logic [7:0] mpl;
        logic [7:0] mcd;
        logic [7:0] ea;
        logic [7:0] eb;
        logic [7:0] ex;
        vecT        v;
        fd = $fopen("tests/multTrace.txt", "r");
        if (fd == 0) begin
            errorCount++;
            $display("trace file tests/multTrace.txt could not be opened");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "#") begin  // skip blanks and comments
                    n = $sscanf(line, "%s %h %h %h %h %h", mode, mpl, mcd, ea, eb, ex);
                    if (n == 6) begin
                        v = '{rerun: (mode == "rerun"), mpl: mpl, mcd: mcd,
                              expA: ea, expB: eb, expX: ex[0]};
                        vecs.push_back(v);
                    end else begin
                        errorCount++;
                        $display("trace line could not be parsed: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // expected product straight from signed integer math
    task automatic addRandom();
        vecT v;
        int  p;
        int  i;
        for (i = 0; i < randomCount; i++) begin
            v.rerun = 1'b0;
            v.mpl   = nextRand();
            v.mcd   = nextRand();
            p       = int'($signed(v.mpl)) * int'($signed(v.mcd));
            v.expA  = p[15:8];
            v.expB  = p[7:0];
            v.expX  = (p < 0);
            vecs.push_back(v);
        end
    endtask

    task automatic runTest(vecT v);
        int errorsBefore;
        errorsBefore = errorCount;
        if (!v.rerun) begin
            sw        = v.mpl;
            loadClear = 1'b1;
            waitCycles(3);
            loadClear = 1'b0;
            waitCycles(3);            // sync delay plus register update
            checkAll("after load", 8'h00, v.mpl, 1'b0);
        end else begin
            checkByte("B before rerun", bVal, v.mpl);
        end
        sw  = v.mcd;
        run = 1'b1;
        waitCycles(22);               // 20 cycle latency plus margin
        checkAll("product", v.expA, v.expB, v.expX);
        waitCycles(4);                // run still held, no second multiply
        checkAll("run held", v.expA, v.expB, v.expX);
        run = 1'b0;
        waitCycles(3);                // back to idle
        if (errorCount != errorsBefore)
            failedTests++;
        $display("test %0d %s %h x %h: A %h B %h X %b %s", testIdx,
                 v.rerun ? "rerun" : "load ", v.mpl, v.mcd, aVal, bVal, xVal,
                 (errorCount == errorsBefore) ? "ok" : "mismatch");
    endtask

    initial begin
        reset     = 1'b1;
        sw        = '0;
        loadClear = 1'b0;
        run       = 1'b0;
        readTrace();
        addRandom();
        cycleLimit = 2 * (vecs.size() * 30 + 10);
        waitCycles(4);                // reset held 4 cycles
        reset = 1'b0;
        waitCycles(2);
        foreach (vecs[i]) begin
            testIdx = i;
            runTest(vecs[i]);
        end
        errorCount += dut.ctrlInst.cmdChecks.failCount;  // bound assertion failures
        $display("%0d tests, %0d failed, %0d errors, %0d assertion failures",
                 vecs.size(), failedTests, errorCount, dut.ctrlInst.cmdChecks.failCount);
        if (errorCount == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule
